// ==== logic/fastFifoPkg.sv ====
package fastFifoPkg;

    // Word width of one FIFO entry
    localparam int DATA_WIDTH_DEFAULT = 16;

    // Address width; one entry stays unused so capacity is 2**DEPTH_LOG2 - 1
    localparam int DEPTH_LOG2_DEFAULT = 4;

    // Retiming stages on the write command and write data path
    localparam int WRITE_STAGES_DEFAULT = 2;

    // Retiming stages on the read address path
    localparam int READ_STAGES_DEFAULT = 1;

    // Memory output registers, 0 for distributed RAM, 2 for block RAM
    localparam int OUT_STAGES_DEFAULT = 2;

    // Depth of the local reset tree inside the controller
    localparam int RESET_STAGES = 2;

endpackage

// ==== logic/fifoMemPort.sv ====
`timescale 1ns/1ps

interface fifoMemPort #(
    parameter int DEPTH_LOG2 = fastFifoPkg::DEPTH_LOG2_DEFAULT
);

    // Write command, already retimed by the controller
    logic                  writeEnable;
    logic [DEPTH_LOG2-1:0] writeAddr;

    // Read address command, already retimed by the controller
    logic                  readAddressStall;
    logic [DEPTH_LOG2-1:0] readAddr;

    modport ctrl (
        output writeEnable,
        output writeAddr,
        output readAddressStall,
        output readAddr
    );

    modport mem (
        input writeEnable,
        input writeAddr,
        input readAddressStall,
        input readAddr
    );

endinterface

// ==== logic/hyperpipe.sv ====
`timescale 1ns/1ps

module hyperpipe #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] dataIn,
    output logic [WIDTH-1:0] dataOut
);

    generate
        if (CYCLES == 0) begin : gWire
            // No retiming requested
            assign dataOut = dataIn;
        end else begin : gRegs
            logic [WIDTH-1:0] stages [CYCLES];

            // Plain shift chain, free for the tools to retime
            always_ff @(posedge clk) begin
                stages[0] <= dataIn;
                for (int i = 1; i < CYCLES; i++) begin
                    stages[i] <= stages[i-1];
                end
            end

            assign dataOut = stages[CYCLES-1];
        end
    endgenerate

endmodule

// ==== logic/fastFifoController.sv ====
`timescale 1ns/1ps

module fastFifoController #(
    parameter int DEPTH_LOG2 = fastFifoPkg::DEPTH_LOG2_DEFAULT,
    parameter int READ_ADDR_STAGES = fastFifoPkg::READ_STAGES_DEFAULT,
    parameter int WRITE_ADDR_STAGES = fastFifoPkg::WRITE_STAGES_DEFAULT,
    parameter int OUT_STAGES = fastFifoPkg::OUT_STAGES_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeEnable,
    input  logic                  readRequest,
    output logic [DEPTH_LOG2-1:0] usedw,
    output logic                  empty,
    output logic                  dataOutValid,
    fifoMemPort.ctrl              memPort
);
    import fastFifoPkg::*;

    logic                  rstLocal;
    logic                  rstD;
    logic [DEPTH_LOG2-1:0] writeAddr;
    logic [DEPTH_LOG2-1:0] readPtr;
    logic                  writeAccept;
    logic [DEPTH_LOG2-1:0] writeCount;
    logic [DEPTH_LOG2-1:0] visibleLimit;
    logic                  isReading;
    logic                  issueRead;
    logic [DEPTH_LOG2-1:0] nextReadAddr;
    logic [DEPTH_LOG2:0]   writeCmd;
    logic [DEPTH_LOG2:0]   writeCmdD;
    logic [DEPTH_LOG2:0]   readCmd;
    logic [DEPTH_LOG2:0]   readCmdD;

    // Local reset tree, plus one extra cycle for the read address preload
    hyperpipe #(.CYCLES(RESET_STAGES), .WIDTH(1)) rstPipe (
        .clk    (clk),
        .dataIn (rst),
        .dataOut(rstLocal)
    );

    always_ff @(posedge clk) begin
        rstD <= rstLocal;
    end

    assign writeAccept = writeEnable && !rstLocal;

    // Write count including this cycle's write, made visible once the data has landed
    assign writeCount = rstLocal ? '0 : writeAddr + DEPTH_LOG2'(writeAccept);

    hyperpipe #(.CYCLES(WRITE_ADDR_STAGES + 1), .WIDTH(DEPTH_LOG2)) limitPipe (
        .clk    (clk),
        .dataIn (writeCount),
        .dataOut(visibleLimit)
    );

    assign usedw = visibleLimit - readPtr;
    assign empty = visibleLimit == readPtr;

    assign isReading = readRequest && !empty && !rstLocal && !rstD;

    // Memory address register always holds the head word ahead of the request
    assign issueRead = isReading || rstD;
    assign nextReadAddr = readPtr + DEPTH_LOG2'(isReading);

    always_ff @(posedge clk) begin
        if (rstLocal) begin
            writeAddr <= '0;
            readPtr <= '0;
        end else begin
            if (writeAccept) begin
                writeAddr <= writeAddr + 1'b1;
            end
            if (isReading) begin
                readPtr <= readPtr + 1'b1;
            end
        end
    end

    hyperpipe #(.CYCLES(READ_ADDR_STAGES + OUT_STAGES), .WIDTH(1)) validPipe (
        .clk    (clk),
        .dataIn (isReading),
        .dataOut(dataOutValid)
    );

    assign writeCmd = {writeAccept, writeAddr};

    hyperpipe #(.CYCLES(WRITE_ADDR_STAGES), .WIDTH(DEPTH_LOG2 + 1)) writePipe (
        .clk    (clk),
        .dataIn (writeCmd),
        .dataOut(writeCmdD)
    );

    assign readCmd = {!issueRead, nextReadAddr};

    hyperpipe #(.CYCLES(READ_ADDR_STAGES), .WIDTH(DEPTH_LOG2 + 1)) readPipe (
        .clk    (clk),
        .dataIn (readCmd),
        .dataOut(readCmdD)
    );

    assign memPort.writeEnable = writeCmdD[DEPTH_LOG2];
    assign memPort.writeAddr = writeCmdD[DEPTH_LOG2-1:0];
    assign memPort.readAddressStall = readCmdD[DEPTH_LOG2];
    assign memPort.readAddr = readCmdD[DEPTH_LOG2-1:0];

endmodule

// ==== logic/fifoMemory.sv ====
`timescale 1ns/1ps

module fifoMemory #(
    parameter int WIDTH = fastFifoPkg::DATA_WIDTH_DEFAULT,
    parameter int DEPTH_LOG2 = fastFifoPkg::DEPTH_LOG2_DEFAULT,
    parameter int OUT_STAGES = fastFifoPkg::OUT_STAGES_DEFAULT
) (
    input  logic             clk,
    fifoMemPort.mem          memPort,
    input  logic [WIDTH-1:0] dataIn,
    output logic [WIDTH-1:0] dataOut
);

    logic [WIDTH-1:0]      memory [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] writeAddrReg;
    logic [WIDTH-1:0]      writeDataReg;
    logic                  writeEnableReg;
    logic [DEPTH_LOG2-1:0] readAddrReg;
    logic [WIDTH-1:0]      dataFromMem;

    // Write port registered once before the array
    always_ff @(posedge clk) begin
        writeAddrReg <= memPort.writeAddr;
        writeDataReg <= dataIn;
        writeEnableReg <= memPort.writeEnable;
        if (writeEnableReg) begin
            memory[writeAddrReg] <= writeDataReg;
        end
    end

    // Read address register, held while stalled
    always_ff @(posedge clk) begin
        if (!memPort.readAddressStall) begin
            readAddrReg <= memPort.readAddr;
        end
    end

    // Mixed-port collision is undefined, as on the real RAM blocks
    assign dataFromMem = (writeEnableReg && writeAddrReg == readAddrReg) ?
                         {WIDTH{1'bx}} : memory[readAddrReg];

    hyperpipe #(.CYCLES(OUT_STAGES), .WIDTH(WIDTH)) outPipe (
        .clk    (clk),
        .dataIn (dataFromMem),
        .dataOut(dataOut)
    );

endmodule

// ==== logic/fastFifo.sv ====
`timescale 1ns/1ps

module fastFifo #(
    parameter int WIDTH = fastFifoPkg::DATA_WIDTH_DEFAULT,
    parameter int DEPTH_LOG2 = fastFifoPkg::DEPTH_LOG2_DEFAULT,
    parameter int WRITE_ADDR_STAGES = fastFifoPkg::WRITE_STAGES_DEFAULT,
    parameter int READ_ADDR_STAGES = fastFifoPkg::READ_STAGES_DEFAULT,
    parameter int OUT_STAGES = fastFifoPkg::OUT_STAGES_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeEnable,
    input  logic                  readRequest,
    input  logic [WIDTH-1:0]      dataIn,
    output logic [WIDTH-1:0]      dataOut,
    output logic [DEPTH_LOG2-1:0] usedw,
    output logic                  empty,
    output logic                  dataOutValid
);

    logic [WIDTH-1:0] dataInD;

    fifoMemPort #(.DEPTH_LOG2(DEPTH_LOG2)) memPort ();

    fastFifoController #(
        .DEPTH_LOG2       (DEPTH_LOG2),
        .READ_ADDR_STAGES (READ_ADDR_STAGES),
        .WRITE_ADDR_STAGES(WRITE_ADDR_STAGES),
        .OUT_STAGES       (OUT_STAGES)
    ) controller (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .readRequest (readRequest),
        .usedw       (usedw),
        .empty       (empty),
        .dataOutValid(dataOutValid),
        .memPort     (memPort.ctrl)
    );

    // Write data follows the same delay as the write command
    hyperpipe #(.CYCLES(WRITE_ADDR_STAGES), .WIDTH(WIDTH)) writeDataPipe (
        .clk    (clk),
        .dataIn (dataIn),
        .dataOut(dataInD)
    );

    fifoMemory #(
        .WIDTH     (WIDTH),
        .DEPTH_LOG2(DEPTH_LOG2),
        .OUT_STAGES(OUT_STAGES)
    ) memory (
        .clk    (clk),
        .memPort(memPort.mem),
        .dataIn (dataInD),
        .dataOut(dataOut)
    );

endmodule

// ==== verification/fastFifoChecker.sv ====
`timescale 1ns/1ps

module fastFifoChecker #(
    parameter int WIDTH = fastFifoPkg::DATA_WIDTH_DEFAULT,
    parameter int DEPTH_LOG2 = fastFifoPkg::DEPTH_LOG2_DEFAULT,
    parameter int WRITE_ADDR_STAGES = fastFifoPkg::WRITE_STAGES_DEFAULT,
    parameter int READ_ADDR_STAGES = fastFifoPkg::READ_STAGES_DEFAULT,
    parameter int OUT_STAGES = fastFifoPkg::OUT_STAGES_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writeEnable,
    input  logic                  readRequest,
    input  logic [WIDTH-1:0]      dataIn,
    input  logic [WIDTH-1:0]      dataOut,
    input  logic [DEPTH_LOG2-1:0] usedw,
    input  logic                  empty,
    input  logic                  dataOutValid,
    input  logic [8*16-1:0]       testName,
    output int                    errorCount
);
    import fastFifoPkg::*;

    localparam int LATENCY = READ_ADDR_STAGES + OUT_STAGES;
    // Outputs stay unknown until reset has filled the limit pipe
    localparam int WARMUP = RESET_STAGES + WRITE_ADDR_STAGES + 1;

    logic [WIDTH-1:0]      words [$];
    logic                  writeLine [WRITE_ADDR_STAGES+1];
    logic                  validLine [LATENCY];
    logic [WIDTH-1:0]      wordLine [LATENCY];
    logic [RESET_STAGES:0] rstHist;
    logic                  resetSeen;
    int                    warmup;
    int                    visibleCount;
    int                    readCount;

    task automatic compareField(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %0s: %0s expected %0h, actual %0h at %0t",
                     testName, what, expected, actual, $time);
        end
    endtask

    task automatic clearModel();
        words.delete();
        visibleCount = 0;
        readCount = 0;
        foreach (writeLine[i]) writeLine[i] = 1'b0;
        foreach (validLine[i]) begin
            validLine[i] = 1'b0;
            wordLine[i] = '0;
        end
    endtask

    initial begin
        errorCount = 0;
        rstHist = '1;
        resetSeen = 1'b0;
        warmup = 0;
        clearModel();
    end

    always @(posedge clk) begin : sampleCycle
        logic                  expEmpty;
        logic [DEPTH_LOG2-1:0] expUsedw;
        logic                  localReset;
        logic                  accept;

        if (rst) resetSeen = 1'b1;
        if (resetSeen && warmup <= WARMUP) warmup++;
        expEmpty = visibleCount == readCount;
        expUsedw = DEPTH_LOG2'(visibleCount - readCount);
        if (warmup > WARMUP) begin
            compareField("empty", 64'(expEmpty), 64'(empty));
            compareField("usedw", 64'(expUsedw), 64'(usedw));
            compareField("dataOutValid", 64'(validLine[LATENCY-1]), 64'(dataOutValid));
            if (validLine[LATENCY-1] && dataOutValid) begin
                compareField("dataOut", 64'(wordLine[LATENCY-1]), 64'(dataOut));
            end
        end

        // The controller sees rst through its own reset pipe
        localReset = rstHist[RESET_STAGES-1];
        accept = readRequest && !expEmpty && !localReset && !rstHist[RESET_STAGES];

        for (int i = LATENCY - 1; i > 0; i--) begin
            validLine[i] = validLine[i-1];
            wordLine[i] = wordLine[i-1];
        end
        validLine[0] = accept;
        wordLine[0] = '0;
        if (accept) begin
            wordLine[0] = words.pop_front();
            readCount++;
        end

        // Writes count only once they reach the end of the visibility line
        for (int i = WRITE_ADDR_STAGES; i > 0; i--) begin
            writeLine[i] = writeLine[i-1];
        end
        writeLine[0] = writeEnable && !localReset;
        if (writeLine[0]) words.push_back(dataIn);
        visibleCount += int'(writeLine[WRITE_ADDR_STAGES]);

        if (localReset) clearModel();
        rstHist = {rstHist[RESET_STAGES-1:0], rst};
    end

endmodule

// ==== verification/fastFifoTb.sv ====
`timescale 1ns/1ps

module fastFifoTb;
    import fastFifoPkg::*;

    localparam int CAPACITY = 2**DEPTH_LOG2_DEFAULT - 1;
    localparam int RANDOM_CYCLES = 1000;
    // Worst-case lengths of the reset, fill, latency, random and drain tests
    localparam int TEST_CYCLES = 20 + 60 + 200 + 1400 + 300;
    localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 2;

    logic                          clk;
    logic                          rst;
    logic                          writeEnable;
    logic                          readRequest;
    logic [DATA_WIDTH_DEFAULT-1:0] dataIn;
    logic [DATA_WIDTH_DEFAULT-1:0] dataOut;
    logic [DEPTH_LOG2_DEFAULT-1:0] usedw;
    logic                          empty;
    logic                          dataOutValid;
    logic [8*16-1:0]               testName;
    logic                          wantWrite;
    logic                          wantRead;
    int                            errorCount;
    int                            cycleCount = 0;
    int                            outstanding;
    int                            passedTests;
    int                            failedTests;
    int                            errorsBefore;

    fastFifo #(
        .WIDTH            (DATA_WIDTH_DEFAULT),
        .DEPTH_LOG2       (DEPTH_LOG2_DEFAULT),
        .WRITE_ADDR_STAGES(WRITE_STAGES_DEFAULT),
        .READ_ADDR_STAGES (READ_STAGES_DEFAULT),
        .OUT_STAGES       (OUT_STAGES_DEFAULT)
    ) i_dut (
        .clk(clk), .rst(rst), .writeEnable(writeEnable), .readRequest(readRequest),
        .dataIn(dataIn), .dataOut(dataOut), .usedw(usedw), .empty(empty),
        .dataOutValid(dataOutValid)
    );

    fastFifoChecker #(
        .WIDTH            (DATA_WIDTH_DEFAULT),
        .DEPTH_LOG2       (DEPTH_LOG2_DEFAULT),
        .WRITE_ADDR_STAGES(WRITE_STAGES_DEFAULT),
        .READ_ADDR_STAGES (READ_STAGES_DEFAULT),
        .OUT_STAGES       (OUT_STAGES_DEFAULT)
    ) monitor (
        .clk(clk), .rst(rst), .writeEnable(writeEnable), .readRequest(readRequest),
        .dataIn(dataIn), .dataOut(dataOut), .usedw(usedw), .empty(empty),
        .dataOutValid(dataOutValid), .testName(testName), .errorCount(errorCount)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [DATA_WIDTH_DEFAULT-1:0] randomWord();
        return DATA_WIDTH_DEFAULT'($urandom);
    endfunction

    // Empty is stable at the falling edge and tells which reads are accepted
    task automatic driveCycle(input logic wr, input logic rd,
                              input logic [DATA_WIDTH_DEFAULT-1:0] data);
        @(negedge clk);
        writeEnable = wr;
        readRequest = rd;
        dataIn = data;
        outstanding += int'(wr) - int'(rd && !empty);
    endtask

    task automatic idleCycles(input int count);
        repeat (count) driveCycle(1'b0, 1'b0, randomWord());
    endtask

    task automatic beginTest(input logic [8*16-1:0] name);
        testName = name;
        errorsBefore = errorCount;
    endtask

    task automatic endTest();
        int errors;
        driveCycle(1'b0, 1'b0, randomWord());
        errors = errorCount - errorsBefore;
        if (errors == 0) begin
            passedTests++;
            $display("PASS %0s", testName);
        end else begin
            failedTests++;
            $display("FAIL %0s with %0d errors", testName, errors);
        end
    endtask

    initial begin
        void'($urandom(27806));
        rst = 1'b1;
        writeEnable = 1'b0;
        readRequest = 1'b0;
        dataIn = '0;
        testName = "none";
        outstanding = 0;
        passedTests = 0;
        failedTests = 0;
        errorsBefore = 0;

        beginTest("reset");
        repeat (3) @(negedge clk);
        rst = 1'b0;
        idleCycles(4);
        // Requests while empty must be dropped
        repeat (6) driveCycle(1'b0, 1'b1, randomWord());
        idleCycles(4);
        endTest();

        beginTest("fill");
        repeat (CAPACITY) driveCycle(1'b1, 1'b0, randomWord());
        while (int'(usedw) != CAPACITY) driveCycle(1'b0, 1'b0, randomWord());
        idleCycles(3);
        endTest();

        beginTest("latency");
        driveCycle(1'b0, 1'b1, randomWord());
        idleCycles(5);
        repeat (3) driveCycle(1'b0, 1'b1, randomWord());
        idleCycles(5);
        repeat (2) begin
            driveCycle(1'b0, 1'b1, randomWord());
            driveCycle(1'b0, 1'b0, randomWord());
        end
        idleCycles(5);
        while (!empty) driveCycle(1'b0, 1'b1, randomWord());
        repeat (5) driveCycle(1'b0, 1'b1, randomWord());
        idleCycles(5);
        endTest();

        // Write-heavy first half, read-heavy second half
        beginTest("random");
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            wantWrite = ($urandom % 4 < (i < RANDOM_CYCLES / 2 ? 3 : 1)) &&
                        (outstanding < CAPACITY);
            wantRead = $urandom % 4 >= (i < RANDOM_CYCLES / 2 ? 3 : 1);
            driveCycle(wantWrite, wantRead, randomWord());
        end
        endTest();

        beginTest("drain");
        while (outstanding > 0) driveCycle(1'b0, 1'b1, randomWord());
        idleCycles(READ_STAGES_DEFAULT + OUT_STAGES_DEFAULT + 3);
        endTest();

        $display("Summary: %0d passed, %0d failed", passedTests, failedTests);
        if (failedTests == 0 && errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== fastFifo.f ====
logic/fastFifoPkg.sv
logic/fifoMemPort.sv
logic/hyperpipe.sv
logic/fastFifoController.sv
logic/fifoMemory.sv
logic/fastFifo.sv
verification/fastFifoChecker.sv
verification/fastFifoTb.sv

// ==== Makefile ====
TOP = fastFifoTb

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f fastFifo.f -o simv

run: build
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f fastFifo.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
